// ==== src/stream_pkg.sv ====
// ====================
// Shared widths and beat types for the stream bypass unit
// Data is a whole number of bytes with one keep bit per byte
// Bypass stage count must be at least 1
// ====================

package stream_pkg;

    // ====================
    // Stream field widths
    // ====================
    localparam int DATA_BYTES  = 8;
    localparam int TID_WIDTH   = 4;
    localparam int TDEST_WIDTH = 4;
    localparam int TUSER_WIDTH = 8;

    // Register stages on the bypass path
    localparam int BYPASS_STAGES = 2;

    // ====================
    // Beat types
    // ====================

    // One beat as it travels between stages
    typedef struct packed {
        logic [DATA_BYTES-1:0][7:0] tdata;
        logic [DATA_BYTES-1:0]      tkeep;
        logic                       tlast;
        logic [TID_WIDTH-1:0]       tid;
        logic [TDEST_WIDTH-1:0]     tdest;
        logic [TUSER_WIDTH-1:0]     tuser;
    } beat_t;

    // Output beat, flagged on the first beat of every packet
    typedef struct packed {
        beat_t beat;
        logic  sop;
    } out_beat_t;

endpackage : stream_pkg

// ==== src/stream_reg_slice.sv ====
// ====================
// Two-entry skid register for a valid/ready stream
// One cycle of latency, one beat per cycle while unstalled
// in_ready is a flop and stays low until the first cycle after reset
// ====================

`timescale 1ns/1ps

module stream_reg_slice #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     aclk,
    input  logic     aresetn,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     ready_q;
    logic     skid_valid;
    payload_t skid_data;
    logic     in_fire;
    logic     main_load;
    logic     skid_valid_next;

    assign in_ready = ready_q;
    assign in_fire  = in_valid & ready_q;

    // Main register is free when empty or when its beat leaves this cycle
    assign main_load = ~out_valid | out_ready;

    always_comb begin
        skid_valid_next = skid_valid;
        if (main_load) begin
            skid_valid_next = 1'b0;
        end else if (in_fire) begin
            skid_valid_next = 1'b1;
        end
    end

    // ====================
    // Control state
    // ====================
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            ready_q    <= 1'b0;
        end else begin
            if (main_load) begin
                out_valid <= skid_valid | in_fire;
            end
            skid_valid <= skid_valid_next;
            // Accept again only once the skid entry is empty
            ready_q    <= ~skid_valid_next;
        end
    end

    // ====================
    // Payload
    // ====================
    always_ff @(posedge aclk) begin
        if (main_load) begin
            // Skid entry is older than anything on the input
            out_data <= skid_valid ? skid_data : in_data;
        end else if (in_fire) begin
            skid_data <= in_data;
        end
    end

endmodule : stream_reg_slice

// ==== src/bypass_steer.sv ====
// ====================
// Per-packet steering between the external block and the bypass path
// bypass is sampled on the first beat of a packet and held until tlast
// Both paths see the same beat, only the chosen one sees valid
// ====================

`timescale 1ns/1ps

module bypass_steer
    import stream_pkg::*;
(
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  bypass,
    // Input stream
    input  logic  s_valid,
    output logic  s_ready,
    input  beat_t s_beat,
    // Towards the external block
    output logic  blk_valid,
    input  logic  blk_ready,
    output beat_t blk_beat,
    // Towards the bypass pipeline
    output logic  byp_valid,
    input  logic  byp_ready,
    output beat_t byp_beat,
    // Path of the most recently started packet, 1 is bypass
    output logic  path_sel
);

    logic active_q;
    logic sop_q;
    logic sel_q;
    logic cur_sel;
    logic s_fire;

    // Between packets the level input decides, inside a packet the held choice
    assign cur_sel = sop_q ? bypass : sel_q;

    // ====================
    // Routing and ready demux
    // ====================
    assign blk_valid = active_q & s_valid & ~cur_sel;
    assign byp_valid = active_q & s_valid & cur_sel;
    assign blk_beat  = s_beat;
    assign byp_beat  = s_beat;
    assign s_ready   = active_q & (cur_sel ? byp_ready : blk_ready);

    assign s_fire   = s_valid & s_ready;
    assign path_sel = sel_q;

    // ====================
    // Packet boundary tracking
    // ====================
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            active_q <= 1'b0;
            sop_q    <= 1'b1;
            sel_q    <= 1'b0;
        end else begin
            // Input opens on the first cycle out of reset
            active_q <= 1'b1;
            if (s_fire) begin
                sop_q <= s_beat.tlast;
                if (sop_q) begin
                    sel_q <= bypass;
                end
            end
        end
    end

endmodule : bypass_steer

// ==== src/output_merge.sv ====
// ====================
// 2:1 merge of the block response and the bypass pipeline
// path_sel picks the source, ready goes back to that source only
// Caller keeps packets whole on each path when path_sel changes
// ====================

`timescale 1ns/1ps

module output_merge
    import stream_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    // 1 selects the bypass path
    input  logic      path_sel,
    // Response from the external block
    input  logic      blk_valid,
    output logic      blk_ready,
    input  beat_t     blk_beat,
    // End of the bypass pipeline
    input  logic      byp_valid,
    output logic      byp_ready,
    input  beat_t     byp_beat,
    // Merged stream with start-of-packet flag
    output logic      out_valid,
    input  logic      out_ready,
    output out_beat_t out_beat
);

    logic  sop_q;
    logic  out_fire;
    beat_t sel_beat;

    // ====================
    // Data mux
    // ====================
    assign out_valid = path_sel ? byp_valid : blk_valid;
    assign sel_beat  = path_sel ? byp_beat  : blk_beat;

    always_comb begin
        out_beat.beat = sel_beat;
        out_beat.sop  = sop_q;
    end

    // ====================
    // Ready demux
    // ====================
    // Unselected path sees ready low and keeps its beat
    assign blk_ready = ~path_sel & out_ready;
    assign byp_ready = path_sel & out_ready;

    assign out_fire = out_valid & out_ready;

    // Start of packet follows output transfers
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            sop_q <= 1'b1;
        end else if (out_fire) begin
            sop_q <= sel_beat.tlast;
        end
    end

endmodule : output_merge

// ==== src/stream_bypass_top.sv ====
// ====================
// Stream bypass unit top level
// Bypass latency is BYPASS_STAGES+1 cycles, block return to output is 1
// Bypass packets must drain before the bypass input changes mode
// ====================

`timescale 1ns/1ps

module stream_bypass_top
    import stream_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    input  logic      bypass,
    // Input stream
    input  logic      s_valid,
    output logic      s_ready,
    input  beat_t     s_beat,
    // Request to the external block
    output logic      blk_req_valid,
    input  logic      blk_req_ready,
    output beat_t     blk_req_beat,
    // Response from the external block
    input  logic      blk_rsp_valid,
    output logic      blk_rsp_ready,
    input  beat_t     blk_rsp_beat,
    // Output stream
    output logic      m_valid,
    input  logic      m_ready,
    output out_beat_t m_beat
);

    // Bypass chain links, index 0 is the steer output
    logic  byp_valid [BYPASS_STAGES+1];
    logic  byp_ready [BYPASS_STAGES+1];
    beat_t byp_beat  [BYPASS_STAGES+1];

    logic      path_sel;
    logic      mrg_valid;
    logic      mrg_ready;
    out_beat_t mrg_beat;

    // ====================
    // Steer stage
    // ====================
    bypass_steer u_steer (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .bypass    (bypass),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .s_beat    (s_beat),
        .blk_valid (blk_req_valid),
        .blk_ready (blk_req_ready),
        .blk_beat  (blk_req_beat),
        .byp_valid (byp_valid[0]),
        .byp_ready (byp_ready[0]),
        .byp_beat  (byp_beat[0]),
        .path_sel  (path_sel)
    );

    // ====================
    // Bypass register stages
    // ====================
    for (genvar i = 0; i < BYPASS_STAGES; i++) begin : g_byp_stage
        stream_reg_slice #(
            .payload_t (beat_t)
        ) u_slice (
            .aclk      (aclk),
            .aresetn   (aresetn),
            .in_valid  (byp_valid[i]),
            .in_ready  (byp_ready[i]),
            .in_data   (byp_beat[i]),
            .out_valid (byp_valid[i+1]),
            .out_ready (byp_ready[i+1]),
            .out_data  (byp_beat[i+1])
        );
    end

    // ====================
    // Merge and output stage
    // ====================
    output_merge u_merge (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .path_sel  (path_sel),
        .blk_valid (blk_rsp_valid),
        .blk_ready (blk_rsp_ready),
        .blk_beat  (blk_rsp_beat),
        .byp_valid (byp_valid[BYPASS_STAGES]),
        .byp_ready (byp_ready[BYPASS_STAGES]),
        .byp_beat  (byp_beat[BYPASS_STAGES]),
        .out_valid (mrg_valid),
        .out_ready (mrg_ready),
        .out_beat  (mrg_beat)
    );

    // Registered output, also decouples m_ready from the block
    stream_reg_slice #(
        .payload_t (out_beat_t)
    ) u_out_slice (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (mrg_valid),
        .in_ready  (mrg_ready),
        .in_data   (mrg_beat),
        .out_valid (m_valid),
        .out_ready (m_ready),
        .out_data  (m_beat)
    );

endmodule : stream_bypass_top

// ==== verification/tb_checks.svh ====
// ====================
// Compare tasks and LFSR step for the bypass testbench
// Included inside the testbench module after fail_run
// ====================

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Fibonacci LFSR, taps for x^8 + x^6 + x^5 + x^4 + 1
function automatic logic [7:0] lfsr_next(input logic [7:0] state);
    logic feedback;
    feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
    return {state[6:0], feedback};
endfunction

// Whole beat payload without the start flag
task automatic check_beat(input string name, input beat_t exp, input beat_t act);
    if (exp !== act) begin
        fail_run($sformatf("FAIL %s beat: expected %h actual %h", name, exp, act));
    end
endtask

// First data word against the test file
task automatic check_data(input string name,
                          input logic [DATA_BYTES-1:0][7:0] exp,
                          input logic [DATA_BYTES-1:0][7:0] act);
    if (exp !== act) begin
        fail_run($sformatf("FAIL %s first word: expected %h actual %h", name, exp, act));
    end
endtask

// Single control bit
task automatic check_flag(input string name, input string what,
                          input logic exp, input logic act);
    if (exp !== act) begin
        fail_run($sformatf("FAIL %s %s: expected %b actual %b", name, what, exp, act));
    end
endtask

// Cycle counts
task automatic check_count(input string name, input string what, input int exp, input int act);
    if (exp != act) begin
        fail_run($sformatf("FAIL %s %s: expected %0d actual %0d", name, what, exp, act));
    end
endtask

`endif

// ==== verification/tb_stream_bypass.sv ====
// ====================
// Testbench for the stream bypass unit, run from the project root
// Each packet drains at the output before the next one starts
// ====================

`timescale 1ns/1ps

module tb_stream_bypass
    import stream_pkg::*;
();

    logic      aclk          = 1'b0;
    logic      aresetn;
    logic      bypass;
    logic      s_valid;
    logic      s_ready;
    beat_t     s_beat;
    logic      blk_req_valid;
    logic      blk_req_ready = 1'b0;
    beat_t     blk_req_beat;
    logic      blk_rsp_valid = 1'b0;
    logic      blk_rsp_ready;
    beat_t     blk_rsp_beat  = '0;
    logic      m_valid;
    logic      m_ready       = 1'b0;
    out_beat_t m_beat;

    // ====================
    // Test table and scoreboard
    // ====================
    string                      t_name  [64];
    logic                       t_byp   [64];
    int                         t_beats [64];
    logic [TID_WIDTH-1:0]       t_tid   [64];
    logic [TDEST_WIDTH-1:0]     t_tdest [64];
    logic [TUSER_WIDTH-1:0]     t_tuser [64];
    logic [DATA_BYTES-1:0][7:0] t_base  [64];
    logic                       t_stall [64];
    logic [DATA_BYTES-1:0][7:0] t_first [64];
    int                         n_tests;

    out_beat_t  exp_q[$];
    int         exp_test_q[$];
    int         in_cyc_q[$];
    beat_t      blk_q[$];
    int         cycle_cnt  = 0;
    int         beats_sent = 0;
    int         beats_seen = 0;
    int         wait_limit = 2000;
    logic [7:0] lfsr_q     = 8'd94;
    logic       stall_en;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_checks.svh"

    stream_bypass_top u_dut (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .bypass        (bypass),
        .s_valid       (s_valid),
        .s_ready       (s_ready),
        .s_beat        (s_beat),
        .blk_req_valid (blk_req_valid),
        .blk_req_ready (blk_req_ready),
        .blk_req_beat  (blk_req_beat),
        .blk_rsp_valid (blk_rsp_valid),
        .blk_rsp_ready (blk_rsp_ready),
        .blk_rsp_beat  (blk_rsp_beat),
        .m_valid       (m_valid),
        .m_ready       (m_ready),
        .m_beat        (m_beat)
    );

    initial begin
        forever #5 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ====================
    // Block model and ready stalls
    // ====================
    // Holds up to two responses, each one cycle after its request
    always begin : block_model
        logic  req_fire;
        logic  rsp_fire;
        logic  in_reset;
        logic  stalls;
        beat_t req_beat;
        @(negedge aclk);
        in_reset = ~aresetn;
        req_fire = blk_req_valid & blk_req_ready;
        rsp_fire = blk_rsp_valid & blk_rsp_ready;
        req_beat = blk_req_beat;
        stalls   = stall_en;
        @(posedge aclk);
        #1;
        if (in_reset) begin
            blk_q.delete();
        end else begin
            if (rsp_fire) begin
                void'(blk_q.pop_front());
            end
            if (req_fire) begin
                req_beat.tdata = ~req_beat.tdata;
                blk_q.push_back(req_beat);
            end
        end
        blk_rsp_valid = (blk_q.size() > 0);
        blk_rsp_beat  = (blk_q.size() > 0) ? blk_q[0] : '0;
        if (in_reset) begin
            // Readies high in reset, the unit keeps its own ready low
            m_ready       = 1'b1;
            blk_req_ready = 1'b1;
        end else if (stalls) begin
            lfsr_q        = lfsr_next(lfsr_q);
            m_ready       = lfsr_q[0];
            lfsr_q        = lfsr_next(lfsr_q);
            blk_req_ready = lfsr_q[0] & (blk_q.size() < 2);
        end else begin
            m_ready       = 1'b1;
            blk_req_ready = (blk_q.size() < 2);
        end
    end

    // ====================
    // Output checker
    // ====================
    always @(negedge aclk) begin : monitor
        out_beat_t exp;
        int        idx;
        int        lat;
        if (!aresetn) begin
            check_flag("reset", "m_valid", 1'b0, m_valid);
            check_flag("reset", "s_ready", 1'b0, s_ready);
            check_flag("reset", "blk_req_valid", 1'b0, blk_req_valid);
            check_flag("reset", "blk_rsp_ready", 1'b0, blk_rsp_ready);
        end else if (m_valid && m_ready) begin
            if (exp_q.size() == 0) begin
                fail_run("Output beat arrived while none was expected");
            end else begin
                exp = exp_q.pop_front();
                idx = exp_test_q.pop_front();
                lat = cycle_cnt - in_cyc_q.pop_front();
                check_beat(t_name[idx], exp.beat, m_beat.beat);
                check_flag(t_name[idx], "sop", exp.sop, m_beat.sop);
                if (exp.sop) begin
                    check_data(t_name[idx], t_first[idx], m_beat.beat.tdata);
                end
                // Latency is fixed only on an unstalled bypass path
                if (t_byp[idx] && !t_stall[idx]) begin
                    check_count(t_name[idx], "latency", BYPASS_STAGES + 1, lat);
                end
                beats_seen++;
            end
        end
    end

    task automatic read_tests();
        int                      fd;
        string                   line;
        logic [255:0]            raw;
        logic [31:0]             f_byp;
        logic [31:0]             f_tid;
        logic [31:0]             f_tdest;
        logic [31:0]             f_tuser;
        logic [31:0]             f_stall;
        logic [8*DATA_BYTES-1:0] f_base;
        logic [8*DATA_BYTES-1:0] f_first;
        int                      f_beats;
        n_tests = 0;
        fd = $fopen("verification/bypass_tests.txt", "r");
        if (fd == 0) begin
            fail_run("Cannot open verification/bypass_tests.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%s %h %d %h %h %h %h %h %h",
                                raw, f_byp, f_beats, f_tid, f_tdest, f_tuser,
                                f_base, f_stall, f_first) != 9) begin
                        fail_run("Malformed line in the test file");
                    end else begin
                        t_name[n_tests]  = $sformatf("%0s", raw);
                        t_byp[n_tests]   = f_byp[0];
                        t_beats[n_tests] = f_beats;
                        t_tid[n_tests]   = f_tid[TID_WIDTH-1:0];
                        t_tdest[n_tests] = f_tdest[TDEST_WIDTH-1:0];
                        t_tuser[n_tests] = f_tuser[TUSER_WIDTH-1:0];
                        t_base[n_tests]  = f_base;
                        t_stall[n_tests] = f_stall[0];
                        t_first[n_tests] = f_first;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One packet, then wait until every beat has left the unit
    task automatic run_test(input int t);
        beat_t     b;
        out_beat_t e;
        int        waited;
        bypass   = t_byp[t];
        stall_en = t_stall[t];
        for (int k = 0; k < t_beats[t]; k++) begin
            b.tdata = t_base[t] + 64'(k);
            b.tkeep = '1;
            if (k == t_beats[t] - 1) begin
                b.tkeep = b.tkeep >> (DATA_BYTES / 2);
            end
            b.tlast = (k == t_beats[t] - 1);
            b.tid   = t_tid[t];
            b.tdest = t_tdest[t];
            b.tuser = t_tuser[t];
            e.beat  = b;
            e.sop   = (k == 0);
            if (!t_byp[t]) begin
                for (int i = 0; i < DATA_BYTES; i++) begin
                    e.beat.tdata[i] = b.tdata[i] ^ 8'hFF;
                end
            end
            exp_q.push_back(e);
            exp_test_q.push_back(t);
            s_valid = 1'b1;
            s_beat  = b;
            waited  = 0;
            @(negedge aclk);
            while (!s_ready) begin
                if (waited >= wait_limit) begin
                    fail_run("Timeout waiting for s_ready on an input beat");
                end else begin
                    waited++;
                    @(negedge aclk);
                end
            end
            in_cyc_q.push_back(cycle_cnt);
            beats_sent++;
            @(posedge aclk);
            #1;
            // Flip the select inside the packet, the held path must not change
            if (k == 0) begin
                bypass = ~t_byp[t];
            end
        end
        s_valid = 1'b0;
        s_beat  = '0;
        waited  = 0;
        @(negedge aclk);
        while (exp_q.size() != 0) begin
            if (waited >= wait_limit) begin
                fail_run($sformatf("Timeout draining the output in %s", t_name[t]));
            end else begin
                waited++;
                @(negedge aclk);
            end
        end
        @(posedge aclk);
        #1;
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin : main
        int waited;
        aresetn  = 1'b0;
        bypass   = 1'b0;
        stall_en = 1'b0;
        s_valid  = 1'b0;
        s_beat   = '0;
        read_tests();
        repeat (3) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        waited  = 0;
        @(negedge aclk);
        while (!s_ready) begin
            if (waited >= wait_limit) begin
                fail_run("Timeout waiting for s_ready after reset");
            end else begin
                waited++;
                @(negedge aclk);
            end
        end
        @(posedge aclk);
        #1;
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        if (beats_sent > 0 && beats_seen == beats_sent) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            fail_run("Output beat count differs from the input beat count");
        end
    end

endmodule : tb_stream_bypass

// ==== files.f ====
+incdir+verification
src/stream_pkg.sv
src/stream_reg_slice.sv
src/bypass_steer.sv
src/output_merge.sv
src/stream_bypass_top.sv
verification/tb_stream_bypass.sv

// ==== Makefile ====
# Verilator build and run for the stream bypass unit
VERILATOR ?= verilator
TOP       ?= tb_stream_bypass
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
SIM       ?= $(OBJ_DIR)/V$(TOP)

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verification/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/bypass_tests.txt ====
# name bypass beats tid tdest tuser base_word stall expected_first_word
# beats is decimal, every other number is hex
byp_single   1 1  1 2 a5 0011223344556677 0 0011223344556677
byp_burst    1 5  2 3 5a 1000000000000000 0 1000000000000000
blk_single   0 1  3 4 c3 00000000000000ff 0 ffffffffffffff00
blk_burst    0 6  4 5 3c 0123456789abcdef 0 fedcba9876543210
blk_stall    0 9  5 6 11 a5a5a5a5a5a5a5a5 1 5a5a5a5a5a5a5a5a
byp_stall    1 9  6 7 22 5555aaaa5555aaaa 1 5555aaaa5555aaaa
byp_again    1 3  7 8 33 0000000100000000 0 0000000100000000
blk_long     0 16 8 9 44 fffffffffffffff0 1 000000000000000f
byp_long     1 16 9 a 55 7ffffffffffffff8 1 7ffffffffffffff8
blk_wrap     0 4  a b 66 fffffffffffffffe 0 0000000000000001
byp_one      1 1  b c 77 deadbeefcafef00d 0 deadbeefcafef00d
blk_one      0 1  c d 88 0f0f0f0f0f0f0f0f 1 f0f0f0f0f0f0f0f0
byp_mix      1 7  d e 99 123456789abcdef0 1 123456789abcdef0
blk_mix      0 7  e f aa 13579bdf02468ace 1 eca86420fdb97531
byp_end      1 2  f 0 bb 0000000000000000 0 0000000000000000
